/* Bender.yml */
package:
  name: rv_id_ex

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rvseed_pkg.sv
      - reg_file.sv
      - inst_decode.sv
      - id_ex_regs.sv
      - alu_exec.sv
      - rv_id_ex_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_id_ex.sv

/* alu_exec.sv */
`timescale 1ns/1ps
`include "rvseed_cfg.svh"

module alu_exec import rvseed_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  id_ex_t                     id_ex_i,
    output wb_t                        wb_o,
    output logic                       result_valid_o,
    output logic [`REG_ADDR_WIDTH-1:0] result_rd_o,
    output logic [`XLEN-1:0]           result_data_o,
    output redirect_t                  redirect_o,
    output logic                       illegal_o,
    output logic [`ILEN-1:0]           illegal_inst_o,
    output logic                       halt_o
);

    logic             live;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [5:0]       shamt;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] jalr_sum;
    logic [`XLEN-1:0] target;
    logic             is_jump;
    logic             taken;
    logic             redir_q;
    logic [`XLEN-1:0] target_q;

    assign live    = id_ex_i.valid & ~halt_o;    // slot squashed after ebreak
    assign op_a    = (id_ex_i.src_sel == SRC_PC_IMM) ? id_ex_i.pc : id_ex_i.rs1_data;
    assign op_b    = (id_ex_i.src_sel == SRC_REG_REG) ? id_ex_i.rs2_data : id_ex_i.imm;
    assign shamt   = op_b[5:0];
    assign is_jump = (id_ex_i.br_op == BR_JAL) || (id_ex_i.br_op == BR_JALR);

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(`XLEN-1){1'b0}}, op_a < op_b};
            ALU_PASS_B: alu_res = op_b;    // lui
            default:    alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        case (id_ex_i.br_op)
            BR_BEQ:           taken = (id_ex_i.rs1_data == id_ex_i.rs2_data);
            BR_BNE:           taken = (id_ex_i.rs1_data != id_ex_i.rs2_data);
            BR_BLT:           taken = $signed(id_ex_i.rs1_data) < $signed(id_ex_i.rs2_data);
            BR_BGE:           taken = $signed(id_ex_i.rs1_data) >= $signed(id_ex_i.rs2_data);
            BR_JAL, BR_JALR:  taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    assign jalr_sum = id_ex_i.rs1_data + id_ex_i.imm;
    assign target   = (id_ex_i.br_op == BR_JALR) ? {jalr_sum[`XLEN-1:1], 1'b0}
                                                 : id_ex_i.pc + id_ex_i.imm;

    assign wb_o.wen  = live & id_ex_i.reg_wen;
    assign wb_o.rd   = id_ex_i.rd;
    assign wb_o.data = is_jump ? id_ex_i.pc + 4 : alu_res;    // link is pc+4

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid_o <= 1'b0;
            redir_q        <= 1'b0;
            illegal_o      <= 1'b0;
            halt_o         <= 1'b0;
        end else begin
            result_valid_o <= wb_o.wen;
            redir_q        <= live & taken;
            illegal_o      <= live & id_ex_i.illegal;
            if (live && id_ex_i.ebreak) begin
                halt_o <= 1'b1;    // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_o.wen) begin
            result_rd_o   <= wb_o.rd;
            result_data_o <= wb_o.data;
        end
        if (live && taken) begin
            target_q <= target;
        end
        if (live && id_ex_i.illegal) begin
            illegal_inst_o <= id_ex_i.inst;
        end
    end

    assign redirect_o.taken  = redir_q;
    assign redirect_o.target = target_q;

    // decode must clear br_op on an illegal word
    a_redir_vs_illegal: assert property (@(posedge clk) disable iff (!rst_n)
        !(redirect_o.taken && illegal_o));

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_o.wen |-> (wb_o.rd != '0));

endmodule

/* id_ex_regs.sv */
`timescale 1ns/1ps
`include "rvseed_cfg.svh"

module id_ex_regs import rvseed_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall_i,
    input  id_ex_t id_ex_i,
    output id_ex_t id_ex_o
);

    id_ex_t slot_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_q    <= '0;
            slot_q.pc <= `RESET_PC;
        end else if (stall_i) begin
            slot_q.valid <= 1'b0;    // keep contents, turn the slot into a bubble
        end else begin
            slot_q <= id_ex_i;
        end
    end

    assign id_ex_o = slot_q;

    // a held slot must not run again in execute
    a_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |=> !id_ex_o.valid);

endmodule

/* inst_decode.sv */
`timescale 1ns/1ps
`include "rvseed_cfg.svh"

module inst_decode import rvseed_pkg::*; (
    input  logic                       inst_valid_i,
    input  inst_fmt_u                  inst_i,
    input  logic [`XLEN-1:0]           pc_i,
    input  logic                       halt_i,
    output logic [`REG_ADDR_WIDTH-1:0] rs1_addr_o,
    output logic [`REG_ADDR_WIDTH-1:0] rs2_addr_o,
    input  logic [`XLEN-1:0]           rs1_data_i,
    input  logic [`XLEN-1:0]           rs2_data_i,
    input  wb_t                        wb_i,
    output id_ex_t                     id_ex_o
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [`ILEN-1:0] INST_EBREAK = 32'h0010_0073;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;
    logic             op_ok;
    logic             shift_ok;
    logic             writes_rd;
    logic             bad;

    assign opcode = inst_i.r.opcode;
    assign funct3 = inst_i.r.funct3;
    assign funct7 = inst_i.r.funct7;

    assign imm_i = {{(`XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
    assign imm_u = {{(`XLEN-32){inst_i.i.imm[11]}}, inst_i.i.imm, inst_i.i.rs1,
                    inst_i.i.funct3, 12'b0};
    assign imm_b = {{(`XLEN-12){inst_i.s.imm_hi[6]}}, inst_i.s.imm_lo[0],
                    inst_i.s.imm_hi[5:0], inst_i.s.imm_lo[4:1], 1'b0};
    assign imm_j = {{(`XLEN-20){inst_i.i.imm[11]}}, inst_i.i.rs1, inst_i.i.funct3,
                    inst_i.i.imm[0], inst_i.i.imm[10:1], 1'b0};    // j bits sit in i view

    // funct7 0100000 only for sub and sra, shifts keep a 6-bit shamt
    assign op_ok    = (funct7 == 7'b0) ||
                      ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
    assign shift_ok = (funct7[6:1] == 6'b0) ||
                      ((funct7[6:1] == 6'b010000) && (funct3 == 3'b101));

    assign rs1_addr_o = inst_i.r.rs1;
    assign rs2_addr_o = inst_i.r.rs2;

    always_comb begin
        id_ex_o          = '0;
        id_ex_o.valid    = inst_valid_i & ~halt_i;    // no new work once halted
        id_ex_o.pc       = pc_i;
        id_ex_o.rd       = inst_i.r.rd;
        id_ex_o.inst     = inst_i;
        id_ex_o.alu_op   = ALU_ADD;
        id_ex_o.br_op    = BR_NONE;
        id_ex_o.src_sel  = SRC_REG_REG;
        id_ex_o.imm      = imm_i;
        id_ex_o.rs1_data = rs1_data_i;
        id_ex_o.rs2_data = rs2_data_i;
        writes_rd        = 1'b0;
        bad              = 1'b0;

        // same-cycle bypass of the slot now in execute
        if (wb_i.wen && (wb_i.rd == rs1_addr_o) && (rs1_addr_o != '0)) begin
            id_ex_o.rs1_data = wb_i.data;
        end
        if (wb_i.wen && (wb_i.rd == rs2_addr_o) && (rs2_addr_o != '0)) begin
            id_ex_o.rs2_data = wb_i.data;
        end

        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                writes_rd = 1'b1;
                if (opcode == OPC_OP_IMM) begin
                    id_ex_o.src_sel = SRC_REG_IMM;
                    bad = (funct3 == 3'b001 || funct3 == 3'b101) && !shift_ok;
                end else begin
                    bad = !op_ok;
                end
                case (funct3)
                    3'b000: id_ex_o.alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b001: id_ex_o.alu_op = ALU_SLL;
                    3'b010: id_ex_o.alu_op = ALU_SLT;
                    3'b011: id_ex_o.alu_op = ALU_SLTU;
                    3'b100: id_ex_o.alu_op = ALU_XOR;
                    3'b101: id_ex_o.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110: id_ex_o.alu_op = ALU_OR;
                    default: id_ex_o.alu_op = ALU_AND;
                endcase
            end
            OPC_LUI: begin
                writes_rd        = 1'b1;
                id_ex_o.imm      = imm_u;
                id_ex_o.src_sel  = SRC_REG_IMM;
                id_ex_o.alu_op   = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                writes_rd        = 1'b1;
                id_ex_o.imm      = imm_u;
                id_ex_o.src_sel  = SRC_PC_IMM;
            end
            OPC_JAL: begin
                writes_rd        = 1'b1;
                id_ex_o.imm      = imm_j;
                id_ex_o.br_op    = BR_JAL;
            end
            OPC_JALR: begin
                writes_rd = 1'b1;
                bad       = (funct3 != 3'b000);
                if (!bad) begin
                    id_ex_o.br_op = BR_JALR;
                end
            end
            OPC_BRANCH: begin
                id_ex_o.imm = imm_b;
                case (funct3)
                    3'b000: id_ex_o.br_op = BR_BEQ;
                    3'b001: id_ex_o.br_op = BR_BNE;
                    3'b100: id_ex_o.br_op = BR_BLT;
                    3'b101: id_ex_o.br_op = BR_BGE;
                    default: bad = 1'b1;    // bltu/bgeu not supported
                endcase
            end
            default: begin
                if (inst_i == INST_EBREAK) begin
                    id_ex_o.ebreak = 1'b1;
                end else begin
                    bad = 1'b1;
                end
            end
        endcase

        id_ex_o.illegal = bad;
        id_ex_o.reg_wen = writes_rd & ~bad & (inst_i.r.rd != '0);    // x0 writes dropped here
    end

endmodule

/* list.f */
+incdir+.
rvseed_pkg.sv
reg_file.sv
inst_decode.sv
id_ex_regs.sv
alu_exec.sv
rv_id_ex_top.sv
tb_rv_id_ex.sv

/* reg_file.sv */
`timescale 1ns/1ps
`include "rvseed_cfg.svh"

module reg_file import rvseed_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr2_i,
    output logic [`XLEN-1:0]           rdata1_o,
    output logic [`XLEN-1:0]           rdata2_o,
    input  wb_t                        wb_i
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wen && (wb_i.rd != '0)) begin    // x0 stays put
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    assign rdata1_o = regs[raddr1_i];    // async read, bypass is in decode
    assign rdata2_o = regs[raddr2_i];

    // x0 must never pick up a value, whatever the write port does
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        regs[0] == '0);

endmodule

/* rv_id_ex_top.sv */
`timescale 1ns/1ps
`include "rvseed_cfg.svh"

module rv_id_ex_top import rvseed_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       inst_valid_i,
    input  logic [`ILEN-1:0]           inst_i,
    input  logic [`XLEN-1:0]           pc_i,
    input  logic                       stall_i,
    output logic                       result_valid_o,
    output logic [`REG_ADDR_WIDTH-1:0] result_rd_o,
    output logic [`XLEN-1:0]           result_data_o,
    output redirect_t                  redirect_o,
    output logic                       illegal_o,
    output logic [`ILEN-1:0]           illegal_inst_o,
    output logic                       halt_o
);

    logic [`REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [`REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [`XLEN-1:0]           rs1_data;
    logic [`XLEN-1:0]           rs2_data;
    wb_t                        wb;            // exec write-back, also the bypass
    id_ex_t                     dec_bundle;
    id_ex_t                     exe_bundle;

    reg_file u_rf (
        .clk      (clk),
        .rst_n    (rst_n),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .wb_i     (wb)
    );

    inst_decode u_dec (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .halt_i       (halt_o),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .wb_i         (wb),
        .id_ex_o      (dec_bundle)
    );

    id_ex_regs u_idex (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall_i (stall_i),
        .id_ex_i (dec_bundle),
        .id_ex_o (exe_bundle)
    );

    alu_exec u_exe (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_ex_i        (exe_bundle),
        .wb_o           (wb),
        .result_valid_o (result_valid_o),
        .result_rd_o    (result_rd_o),
        .result_data_o  (result_data_o),
        .redirect_o     (redirect_o),
        .illegal_o      (illegal_o),
        .illegal_inst_o (illegal_inst_o),
        .halt_o         (halt_o)
    );

endmodule

/* rvseed_cfg.svh */
`ifndef RVSEED_CFG_SVH
`define RVSEED_CFG_SVH

// data path and pc width
`define XLEN 64

// instruction word width
`define ILEN 32

// register file geometry
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

// pc parked in the id/ex slot out of reset
`define RESET_PC 64'h0000_0000_8000_0000

`endif

/* rvseed_pkg.sv */
package rvseed_pkg;

    `include "rvseed_cfg.svh"

    typedef struct packed {
        logic [6:0]                 funct7;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                 opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]                imm;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                 opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]                 imm_hi;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [4:0]                 imm_lo;
        logic [6:0]                 opcode;
    } s_fmt_t;                                  // store layout, reused for b-type

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
    } inst_fmt_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_JAL, BR_JALR
    } br_op_e;

    // bit 1 picks pc for operand a, bit 0 picks imm for operand b
    typedef enum logic [1:0] {
        SRC_REG_REG = 2'b00,
        SRC_REG_IMM = 2'b01,
        SRC_PC_IMM  = 2'b11
    } src_sel_e;

    typedef struct packed {
        logic                       valid;
        logic [`XLEN-1:0]           pc;
        logic [`XLEN-1:0]           rs1_data;
        logic [`XLEN-1:0]           rs2_data;
        logic [`XLEN-1:0]           imm;
        alu_op_e                    alu_op;
        br_op_e                     br_op;
        src_sel_e                   src_sel;
        logic                       reg_wen;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic                       ebreak;
        logic                       illegal;
        logic [`ILEN-1:0]           inst;
    } id_ex_t;

    typedef struct packed {
        logic                       wen;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`XLEN-1:0]           data;
    } wb_t;

    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } redirect_t;

endpackage

/* tb_rv_id_ex.sv */
`timescale 1ns/1ps
`include "rvseed_cfg.svh"

module tb_rv_id_ex import rvseed_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int N_TESTS = 5;
    localparam int CYCLES_PER_TEST = 200;

    typedef struct packed {
        logic        res_v;
        logic [4:0]  rd;
        logic [63:0] data;
        logic        taken;
        logic [63:0] target;
        logic        ill;
        logic [31:0] inst;
        logic        halt;
    } expect_t;

    logic                       clk;
    logic                       rst_n;
    logic                       inst_valid_i;
    logic [`ILEN-1:0]           inst_i;
    logic [`XLEN-1:0]           pc_i;
    logic                       stall_i;
    logic                       result_valid_o;
    logic [`REG_ADDR_WIDTH-1:0] result_rd_o;
    logic [`XLEN-1:0]           result_data_o;
    redirect_t                  redirect_o;
    logic                       illegal_o;
    logic [`ILEN-1:0]           illegal_inst_o;
    logic                       halt_o;

    logic [63:0] mregs [32];    // model register file
    logic        mhalt;
    logic [63:0] cur_pc;
    expect_t     pipe0;         // word just driven
    expect_t     pipe1;         // word whose outputs are due now
    int          errors;
    int          checks;
    int unsigned seed;

    rv_id_ex_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .pc_i           (pc_i),
        .stall_i        (stall_i),
        .result_valid_o (result_valid_o),
        .result_rd_o    (result_rd_o),
        .result_data_o  (result_data_o),
        .redirect_o     (redirect_o),
        .illegal_o      (illegal_o),
        .illegal_inst_o (illegal_inst_o),
        .halt_o         (halt_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // reference alu per the isa, alt selects sub and sra
    function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [63:0] a, input logic [63:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return {63'b0, $signed(a) < $signed(b)};
            3'd3: return {63'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic expect_t idle_record();
        expect_t e;
        e = '0;
        e.halt = mhalt;
        return e;
    endfunction

    function automatic expect_t result_record(input logic [4:0] rd, input logic [63:0] v);
        expect_t e;
        e = idle_record();
        e.res_v = (rd != 5'd0);    // x0 writes give no result
        e.rd = rd;
        e.data = v;
        return e;
    endfunction

    task automatic expect_eq(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs(input expect_t e);
        expect_eq("result_valid_o", result_valid_o, e.res_v);
        if (e.res_v) begin
            expect_eq("result_rd_o", result_rd_o, e.rd);
            expect_eq("result_data_o", result_data_o, e.data);
        end
        expect_eq("redirect_o.taken", redirect_o.taken, e.taken);
        if (e.taken) begin
            expect_eq("redirect_o.target", redirect_o.target, e.target);
        end
        expect_eq("illegal_o", illegal_o, e.ill);
        if (e.ill) begin
            expect_eq("illegal_inst_o", illegal_inst_o, e.inst);
        end
        expect_eq("halt_o", halt_o, e.halt);
    endtask

    // one cycle: check the word from two cycles back, then drive the next one
    task automatic clock_step(input logic v, input logic [31:0] w, input logic st,
                              input expect_t e);
        @(negedge clk);
        check_outputs(pipe1);
        pipe1 = pipe0;
        pipe0 = (v && !st) ? e : idle_record();
        inst_valid_i = v;
        inst_i = w;
        pc_i = cur_pc;
        stall_i = st;
        if (v && !st) begin
            cur_pc = cur_pc + 4;
        end
    endtask

    task automatic commit_word(input logic [31:0] w, input expect_t e);
        if (mhalt) begin
            e = idle_record();    // squashed after ebreak
        end else if (e.res_v) begin
            mregs[e.rd] = e.data;
        end
        e.halt = mhalt;
        clock_step(1'b1, w, 1'b0, e);
    endtask

    task automatic drain();
        repeat (2) clock_step(1'b0, 32'h0, 1'b0, idle_record());
    endtask

    task automatic alu_rr(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
        expect_t e;
        e = result_record(rd, alu_ref(f3, f7[5], mregs[rs1], mregs[rs2]));
        commit_word(enc_r(f7, rs2, rs1, f3, rd), e);
    endtask

    task automatic alu_ri(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
        expect_t e;
        logic    alt;
        alt = (f3 == 3'd5) && imm[10];
        e = result_record(rd, alu_ref(f3, alt, mregs[rs1], {{52{imm[11]}}, imm}));
        commit_word(enc_i(imm, rs1, f3, rd, 7'h13), e);
    endtask

    task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
        commit_word({imm, rd, 7'h37}, result_record(rd, {{32{imm[19]}}, imm, 12'h000}));
    endtask

    task automatic add_upper_pc(input logic [4:0] rd, input logic [19:0] imm);
        expect_t e;
        e = result_record(rd, cur_pc + {{32{imm[19]}}, imm, 12'h000});
        commit_word({imm, rd, 7'h17}, e);
    endtask

    task automatic branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic [12:0] imm);
        expect_t     e;
        logic [63:0] a;
        logic [63:0] b;
        a = mregs[rs1];
        b = mregs[rs2];
        e = idle_record();
        case (f3)
            3'd0: e.taken = (a == b);
            3'd1: e.taken = (a != b);
            3'd4: e.taken = $signed(a) < $signed(b);
            default: e.taken = $signed(a) >= $signed(b);
        endcase
        e.target = cur_pc + {{51{imm[12]}}, imm};
        commit_word(enc_b(imm, rs2, rs1, f3), e);
    endtask

    task automatic jump_link(input logic [4:0] rd, input logic [20:0] imm);
        expect_t e;
        e = result_record(rd, cur_pc + 4);
        e.taken = 1'b1;
        e.target = cur_pc + {{43{imm[20]}}, imm};
        commit_word(enc_j(imm, rd), e);
    endtask

    task automatic jump_reg(input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [11:0] imm);
        expect_t     e;
        logic [63:0] sum;
        sum = mregs[rs1] + {{52{imm[11]}}, imm};
        e = result_record(rd, cur_pc + 4);
        e.taken = 1'b1;
        e.target = {sum[63:1], 1'b0};    // bit 0 dropped
        commit_word(enc_i(imm, rs1, 3'd0, rd, 7'h67), e);
    endtask

    task automatic send_illegal(input logic [31:0] w);
        expect_t e;
        e = idle_record();
        e.ill = 1'b1;
        e.inst = w;
        commit_word(w, e);
    endtask

    task automatic send_ebreak();
        mhalt = 1'b1;
        commit_word(32'h0010_0073, idle_record());
    endtask

    task automatic test_reset();
        @(negedge clk);
        expect_eq("result_valid_o", result_valid_o, 1'b0);
        expect_eq("redirect_o.taken", redirect_o.taken, 1'b0);
        expect_eq("illegal_o", illegal_o, 1'b0);
        expect_eq("halt_o", halt_o, 1'b0);
        alu_rr(7'h00, 3'd0, 5'd3, 5'd1, 5'd2);    // cleared regs give 0
        drain();
    endtask

    task automatic test_arith();
        alu_ri(3'd0, 5'd1, 5'd0, 12'h123);
        repeat (2) begin
            load_upper(5'd1, 20'($urandom));
            alu_ri(3'd0, 5'd1, 5'd1, 12'($urandom));    // needs the bypass
            load_upper(5'd2, 20'($urandom));
            alu_ri(3'd0, 5'd2, 5'd2, 12'($urandom));
            for (int i = 0; i < 8; i++) begin
                alu_rr(7'h00, i[2:0], 5'(3 + i), 5'd1, 5'd2);
            end
            alu_rr(7'h20, 3'd0, 5'd11, 5'd1, 5'd2);
            alu_rr(7'h20, 3'd5, 5'd12, 5'd1, 5'd2);
            alu_ri(3'd1, 5'd13, 5'd12, 12'h00d);
            alu_ri(3'd5, 5'd14, 5'd13, 12'h407);
            alu_ri(3'd5, 5'd15, 5'd14, 12'h021);
            alu_rr(7'h00, 3'd0, 5'd16, 5'd15, 5'd14);
            alu_rr(7'h20, 3'd0, 5'd17, 5'd16, 5'd1);
        end
        add_upper_pc(5'd18, 20'h00012);
        alu_ri(3'd0, 5'd0, 5'd1, 12'h7ff);    // x0 target
        alu_rr(7'h00, 3'd0, 5'd19, 5'd0, 5'd2);
        drain();
    endtask

    task automatic test_branch();
        alu_ri(3'd0, 5'd5, 5'd0, 12'd5);
        alu_ri(3'd0, 5'd6, 5'd0, 12'hffd);    // -3
        branch_word(3'd0, 5'd5, 5'd5, 13'h0010);
        branch_word(3'd0, 5'd5, 5'd6, 13'h1ff8);
        branch_word(3'd1, 5'd5, 5'd6, 13'h0020);
        branch_word(3'd1, 5'd5, 5'd5, 13'h0020);
        branch_word(3'd4, 5'd6, 5'd5, 13'h1f00);
        branch_word(3'd4, 5'd5, 5'd6, 13'h0040);
        branch_word(3'd5, 5'd5, 5'd6, 13'h0008);
        branch_word(3'd5, 5'd6, 5'd5, 13'h0008);
        branch_word(3'd5, 5'd5, 5'd5, 13'h1ffc);
        jump_link(5'd1, 21'h000100);
        jump_link(5'd0, 21'h1ffff0);
        jump_reg(5'd7, 5'd5, 12'h021);
        alu_ri(3'd0, 5'd8, 5'd0, 12'h101);
        jump_reg(5'd9, 5'd8, 12'hff0);
        drain();
    endtask

    task automatic test_stall();
        logic [31:0] w;
        w = enc_i(12'h001, 5'd8, 3'd0, 5'd8, 7'h13);    // x8 += 1
        alu_ri(3'd0, 5'd8, 5'd0, 12'h040);
        clock_step(1'b1, w, 1'b1, idle_record());
        clock_step(1'b1, w, 1'b1, idle_record());
        alu_ri(3'd0, 5'd8, 5'd8, 12'h001);
        alu_rr(7'h00, 3'd0, 5'd10, 5'd8, 5'd0);
        drain();
    endtask

    task automatic test_halt();
        send_illegal(32'h1234_560b);    // rd field is x12
        alu_rr(7'h00, 3'd0, 5'd13, 5'd12, 5'd0);
        send_ebreak();
        alu_ri(3'd0, 5'd14, 5'd0, 12'h007);
        jump_link(5'd1, 21'h000040);
        drain();
    endtask

    initial begin
        seed = $urandom(18893);
        clk = 1'b0;
        rst_n = 1'b0;
        inst_valid_i = 1'b0;
        inst_i = '0;
        pc_i = '0;
        stall_i = 1'b0;
        errors = 0;
        checks = 0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        mhalt = 1'b0;
        cur_pc = 64'h0000_0000_8000_0000;
        pipe0 = '0;
        pipe1 = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_arith();
        test_branch();
        test_stall();
        test_halt();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog sized from the test count
    initial begin
        #(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("timeout: the tests did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
